// ==== src/axis_sw_pkg.sv ====
package axis_sw_pkg;

    //////////////////////////////
    // Widths

    parameter int data_width  = 32;
    parameter int num_sources = 3;

    typedef logic [data_width-1:0]   data_t;
    typedef logic [data_width/8-1:0] keep_t;
    typedef logic [1:0]              user_t;
    typedef logic [1:0]              tid_t;
    typedef logic [num_sources-1:0]  src_vec_t;

    //////////////////////////////
    // Beats

    // One stream beat, no routing
    typedef struct packed {
        data_t tdata;
        keep_t tkeep;
        logic  tlast;
        user_t tuser;
    } axis_beat_t;

    // Beat on the serial link, tagged with its source or destination
    typedef struct packed {
        axis_beat_t beat;
        tid_t       tid;
    } link_beat_t;

    // Source and destination indices
    localparam tid_t tid_user     = 2'd0;
    localparam tid_t tid_bridge   = 2'd1;
    localparam tid_t tid_analyzer = 2'd2;

    typedef enum logic {
        arb_idle,
        arb_frame
    } arb_state_t;

endpackage

// ==== src/frame_arbiter.sv ====
`timescale 1ns/1ps

module frame_arbiter (
    input  logic                  axis_clk,
    input  logic                  axi_reset_n,
    input  axis_sw_pkg::src_vec_t request,
    input  logic                  taken,
    input  logic                  taken_last,
    output axis_sw_pkg::src_vec_t grant
);
    import axis_sw_pkg::*;

    arb_state_t state;
    logic [1:0] ptr;
    src_vec_t   rot_req;
    src_vec_t   rot_pick;
    src_vec_t   next_grant;
    logic [1:0] grant_idx;
    logic       frame_end;

    // Pointer source lands on bit 0
    always_comb begin
        for (int i = 0; i < num_sources; i++) begin
            rot_req[i] = request[(i + ptr) % num_sources];
        end
    end

    // Lowest set bit wins
    always_comb begin
        rot_pick = '0;
        for (int i = num_sources - 1; i >= 0; i--) begin
            if (rot_req[i]) begin
                rot_pick    = '0;
                rot_pick[i] = 1'b1;
            end
        end
    end

    // Undo the rotation
    always_comb begin
        next_grant = '0;
        for (int i = 0; i < num_sources; i++) begin
            next_grant[(i + ptr) % num_sources] = rot_pick[i];
        end
    end

    assign grant_idx = grant[2] ? 2'd2 : (grant[1] ? 2'd1 : 2'd0);
    assign frame_end = taken && taken_last;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            state <= arb_idle;
            ptr   <= '0;
            grant <= '0;
        end else begin
            case (state)
                arb_idle: begin
                    if (|request) begin
                        grant <= next_grant;
                        state <= arb_frame;
                    end
                end
                arb_frame: begin
                    if (frame_end) begin
                        grant <= '0;
                        state <= arb_idle;
                        // Next search starts one past the finished source
                        ptr   <= (grant_idx == 2'(num_sources - 1)) ? 2'd0 : grant_idx + 2'd1;
                    end
                end
                default: state <= arb_idle;
            endcase
        end
    end

    a_grant_onehot: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        $onehot0(grant));

    a_grant_held: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        state == arb_frame && !frame_end |=> $stable(grant) && grant != '0);

endmodule

// ==== src/upstream_mux.sv ====
`timescale 1ns/1ps

module upstream_mux (
    input  logic                    axis_clk,
    input  logic                    axi_reset_n,
    input  axis_sw_pkg::src_vec_t   grant,
    input  axis_sw_pkg::axis_beat_t up_beat,
    input  axis_sw_pkg::axis_beat_t aa_beat,
    input  axis_sw_pkg::axis_beat_t la_beat,
    input  axis_sw_pkg::src_vec_t   valids,
    output axis_sw_pkg::src_vec_t   readies,
    output axis_sw_pkg::link_beat_t link_tx_beat,
    output logic                    link_tx_valid,
    input  logic                    link_tx_ready,
    output logic                    taken,
    output logic                    taken_last
);
    import axis_sw_pkg::*;

    axis_beat_t sel_beat;
    tid_t       sel_tid;
    logic       sel_valid;
    logic       can_load;

    always_comb begin
        sel_beat = up_beat;
        sel_tid  = tid_user;
        if (grant[2]) begin
            sel_beat = la_beat;
            sel_tid  = tid_analyzer;
        end else if (grant[1]) begin
            sel_beat = aa_beat;
            sel_tid  = tid_bridge;
        end
    end

    assign sel_valid = |(grant & valids);

    // Register free or draining this cycle
    assign can_load   = !link_tx_valid || link_tx_ready;
    assign readies    = grant & {num_sources{can_load}};
    assign taken      = sel_valid && can_load;
    assign taken_last = sel_beat.tlast;

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            link_tx_valid <= 1'b0;
        end else if (can_load) begin
            link_tx_valid <= taken;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (taken) begin
            link_tx_beat.beat <= sel_beat;
            link_tx_beat.tid  <= sel_tid;
        end
    end

    a_tx_hold: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        link_tx_valid && !link_tx_ready |=> link_tx_valid && $stable(link_tx_beat));

endmodule

// ==== src/downstream_demux.sv ====
`timescale 1ns/1ps

module downstream_demux #(
    parameter int fifo_depth     = 16,
    parameter int fifo_threshold = 6
) (
    input  logic                    axis_clk,
    input  logic                    axi_reset_n,
    input  axis_sw_pkg::link_beat_t link_rx_beat,
    input  logic                    link_rx_valid,
    output logic                    link_rx_ready,
    output axis_sw_pkg::axis_beat_t up_rx_beat,
    output logic                    up_rx_valid,
    input  logic                    up_rx_ready,
    output axis_sw_pkg::axis_beat_t aa_rx_beat,
    output logic                    aa_rx_valid,
    input  logic                    aa_rx_ready
);
    import axis_sw_pkg::*;

    localparam int addr_width = $clog2(fifo_depth);

    link_beat_t            mem [fifo_depth];
    logic [addr_width:0]   wr_ptr;
    logic [addr_width:0]   rd_ptr;
    logic [addr_width:0]   fill_count;
    logic                  empty;
    logic                  full;
    logic                  pop;
    link_beat_t            head;

    //////////////////////////////
    // FIFO

    assign fill_count = wr_ptr - rd_ptr;
    assign empty      = (wr_ptr == rd_ptr);
    assign full       = (wr_ptr[addr_width] != rd_ptr[addr_width]) &&
                        (wr_ptr[addr_width-1:0] == rd_ptr[addr_width-1:0]);

    // Link stops late, so back off early
    assign link_rx_ready = (fill_count <= fifo_threshold);

    always_ff @(posedge axis_clk) begin
        if (link_rx_valid) begin
            mem[wr_ptr[addr_width-1:0]] <= link_rx_beat;
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            wr_ptr <= '0;
        end else if (link_rx_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge axis_clk or negedge axi_reset_n) begin
        if (!axi_reset_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    //////////////////////////////
    // Routing by tid

    assign head       = mem[rd_ptr[addr_width-1:0]];
    assign up_rx_beat = head.beat;
    assign aa_rx_beat = head.beat;

    always_comb begin
        up_rx_valid = 1'b0;
        aa_rx_valid = 1'b0;
        pop         = 1'b0;
        if (!empty) begin
            case (head.tid)
                tid_user: begin
                    up_rx_valid = 1'b1;
                    pop         = up_rx_ready;
                end
                tid_bridge: begin
                    aa_rx_valid = 1'b1;
                    pop         = aa_rx_ready;
                end
                // No destination, drop it
                default: pop = 1'b1;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge axis_clk) disable iff (!axi_reset_n)
        link_rx_valid |-> !full);

endmodule

// ==== src/axis_switch.sv ====
`timescale 1ns/1ps

module axis_switch #(
    parameter int fifo_depth     = 16,
    parameter int fifo_threshold = 6
) (
    input  logic                    axis_clk,
    input  logic                    axi_reset_n,

    // Upstream sources
    input  axis_sw_pkg::axis_beat_t up_beat,
    input  logic                    up_valid,
    output logic                    up_ready,
    input  axis_sw_pkg::axis_beat_t aa_beat,
    input  logic                    aa_valid,
    output logic                    aa_ready,
    input  axis_sw_pkg::axis_beat_t la_beat,
    input  logic                    la_valid,
    output logic                    la_ready,

    // Serial link
    output axis_sw_pkg::link_beat_t link_tx_beat,
    output logic                    link_tx_valid,
    input  logic                    link_tx_ready,
    input  axis_sw_pkg::link_beat_t link_rx_beat,
    input  logic                    link_rx_valid,
    output logic                    link_rx_ready,

    // Downstream destinations
    output axis_sw_pkg::axis_beat_t up_rx_beat,
    output logic                    up_rx_valid,
    input  logic                    up_rx_ready,
    output axis_sw_pkg::axis_beat_t aa_rx_beat,
    output logic                    aa_rx_valid,
    input  logic                    aa_rx_ready
);
    import axis_sw_pkg::*;

    wire src_vec_t valid_vec = {la_valid, aa_valid, up_valid};
    src_vec_t      grant;
    logic          taken;
    logic          taken_last;

    //////////////////////////////
    // Upstream

    frame_arbiter frame_arbiter_i (
        .axis_clk    (axis_clk),
        .axi_reset_n (axi_reset_n),
        .request     (valid_vec),
        .taken       (taken),
        .taken_last  (taken_last),
        .grant       (grant)
    );

    upstream_mux upstream_mux_i (
        .axis_clk      (axis_clk),
        .axi_reset_n   (axi_reset_n),
        .grant         (grant),
        .up_beat       (up_beat),
        .aa_beat       (aa_beat),
        .la_beat       (la_beat),
        .valids        (valid_vec),
        .readies       ({la_ready, aa_ready, up_ready}),
        .link_tx_beat  (link_tx_beat),
        .link_tx_valid (link_tx_valid),
        .link_tx_ready (link_tx_ready),
        .taken         (taken),
        .taken_last    (taken_last)
    );

    //////////////////////////////
    // Downstream

    downstream_demux #(
        .fifo_depth     (fifo_depth),
        .fifo_threshold (fifo_threshold)
    ) downstream_demux_i (
        .axis_clk      (axis_clk),
        .axi_reset_n   (axi_reset_n),
        .link_rx_beat  (link_rx_beat),
        .link_rx_valid (link_rx_valid),
        .link_rx_ready (link_rx_ready),
        .up_rx_beat    (up_rx_beat),
        .up_rx_valid   (up_rx_valid),
        .up_rx_ready   (up_rx_ready),
        .aa_rx_beat    (aa_rx_beat),
        .aa_rx_valid   (aa_rx_valid),
        .aa_rx_ready   (aa_rx_ready)
    );

endmodule

// ==== bench/axis_switch_checker.sv ====
`timescale 1ns/1ps

module axis_switch_checker (
    input logic                    axis_clk,
    input logic                    axi_reset_n,
    input axis_sw_pkg::link_beat_t link_tx_beat,
    input logic                    link_tx_valid,
    input logic                    link_tx_ready,
    input logic                    link_rx_ready,
    input axis_sw_pkg::axis_beat_t up_rx_beat,
    input logic                    up_rx_valid,
    input logic                    up_rx_ready,
    input axis_sw_pkg::axis_beat_t aa_rx_beat,
    input logic                    aa_rx_valid,
    input logic                    aa_rx_ready
);
    import axis_sw_pkg::*;

    link_beat_t link_q[$];
    axis_beat_t up_q[$];
    axis_beat_t aa_q[$];
    int         error_count = 0;
    int         test_errors = 0;
    int         tests_failed = 0;
    int         tests_run = 0;

    function automatic int pending();
        return link_q.size() + up_q.size() + aa_q.size();
    endfunction

    task automatic expect_beat(input logic dir, input tid_t dest, input axis_beat_t beat);
        if (!dir) begin
            link_q.push_back('{beat: beat, tid: dest});
        end else if (dest == tid_user) begin
            up_q.push_back(beat);
        end else if (dest == tid_bridge) begin
            aa_q.push_back(beat);
        end
    endtask

    task automatic compare(input string name, input logic [40:0] got, input logic [40:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %0h, expected %0h", name, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic unexpected(input string port);
        $display("A beat arrived on %s with none expected there", port);
        error_count++;
        test_errors++;
    endtask

    //////////////////////////////
    // Transfers

    always @(posedge axis_clk) begin
        if (axi_reset_n && link_tx_valid && link_tx_ready) begin
            if (link_q.size() == 0) begin
                unexpected("link_tx");
            end else begin
                compare("link_tx_beat", link_tx_beat, link_q.pop_front());
            end
        end
        if (axi_reset_n && up_rx_valid && up_rx_ready) begin
            if (up_q.size() == 0) begin
                unexpected("up_rx");
            end else begin
                compare("up_rx_beat", up_rx_beat, up_q.pop_front());
            end
        end
        if (axi_reset_n && aa_rx_valid && aa_rx_ready) begin
            if (aa_q.size() == 0) begin
                unexpected("aa_rx");
            end else begin
                compare("aa_rx_beat", aa_rx_beat, aa_q.pop_front());
            end
        end
    end

    //////////////////////////////
    // Levels and results

    task automatic check_idle();
        @(negedge axis_clk);
        compare("link_tx_valid", link_tx_valid, 1'b0);
        compare("up_rx_valid", up_rx_valid, 1'b0);
        compare("aa_rx_valid", aa_rx_valid, 1'b0);
        compare("link_rx_ready", link_rx_ready, 1'b1);
    endtask

    task automatic check_rx_ready(input logic level);
        @(negedge axis_clk);
        compare("link_rx_ready", link_rx_ready, level);
    endtask

    task automatic end_test(input int test);
        if (pending() != 0) begin
            $display("test %0d ended with %0d expected beats missing", test, pending());
            error_count++;
            test_errors++;
            link_q.delete();
            up_q.delete();
            aa_q.delete();
        end
        if (test_errors == 0) begin
            $display("test %0d: ok", test);
        end else begin
            $display("test %0d: %0d errors", test, test_errors);
            tests_failed++;
        end
        tests_run++;
        test_errors = 0;
    endtask

    task automatic report();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
    endtask

endmodule

// ==== bench/axis_switch_tb.sv ====
`timescale 1ns/1ps

module axis_switch_tb;
    import axis_sw_pkg::*;

    localparam int max_lines  = 64;
    localparam int wait_limit = 500;

    // One line of the golden file
    typedef struct packed {
        logic [7:0] test;
        logic       dir;
        tid_t       sel;
        axis_beat_t beat;
        logic [1:0] mode;
        tid_t       dest;
    } golden_t;

    logic       axis_clk;
    logic       axi_reset_n;
    axis_beat_t src_beat [num_sources];
    src_vec_t   src_valid;
    src_vec_t   src_ready;
    link_beat_t link_tx_beat;
    logic       link_tx_valid;
    logic       link_tx_ready;
    link_beat_t link_rx_beat;
    logic       link_rx_valid;
    logic       link_rx_ready;
    axis_beat_t up_rx_beat;
    logic       up_rx_valid;
    logic       up_rx_ready;
    axis_beat_t aa_rx_beat;
    logic       aa_rx_valid;
    logic       aa_rx_ready;
    golden_t    golden [max_lines];
    int         line_count;
    logic       aborted;

    axis_switch #(
        .fifo_depth     (16),
        .fifo_threshold (6)
    ) axis_switch_i (
        .up_beat  (src_beat[0]),
        .up_valid (src_valid[0]),
        .up_ready (src_ready[0]),
        .aa_beat  (src_beat[1]),
        .aa_valid (src_valid[1]),
        .aa_ready (src_ready[1]),
        .la_beat  (src_beat[2]),
        .la_valid (src_valid[2]),
        .la_ready (src_ready[2]),
        .*
    );

    axis_switch_checker axis_switch_checker_i (.*);

    initial begin
        axis_clk = 1'b0;
        forever begin
            #5 axis_clk = ~axis_clk;
        end
    end

    task automatic note_timeout(input string what);
        $display("Timeout: %s", what);
        aborted = 1'b1;
    endtask

    task automatic drive_source(input int s, input int first, input int stop);
        int n;
        for (int i = first; i < stop; i++) begin
            if (golden[i].sel == s) begin
                src_beat[s]  <= golden[i].beat;
                src_valid[s] <= 1'b1;
                n = 0;
                @(negedge axis_clk);
                while (!src_ready[s] && n < wait_limit) begin
                    @(negedge axis_clk);
                    n++;
                end
                if (!src_ready[s]) begin
                    note_timeout($sformatf("source %0d was never granted", s));
                end
                @(posedge axis_clk);
            end
        end
        src_valid[s] <= 1'b0;
    endtask

    // Runs until every expected link beat is seen
    task automatic pace_tx_ready(input logic gaps);
        for (int n = 0; n < wait_limit; n++) begin
            link_tx_ready <= !gaps || ($urandom % 4 != 0);
            @(negedge axis_clk);
            if (axis_switch_checker_i.pending() == 0) begin
                break;
            end
            @(posedge axis_clk);
        end
        if (axis_switch_checker_i.pending() != 0) begin
            note_timeout("link_tx beats still missing");
        end
        @(posedge axis_clk);
        link_tx_ready <= 1'b1;
    endtask

    // Link sees ready one cycle late, inside the FIFO slack
    task automatic send_link_beats(input int first, input int stop);
        int   i;
        logic room;
        i = first;
        for (int n = 0; i < stop && n < wait_limit; n++) begin
            @(negedge axis_clk);
            room = link_rx_ready;
            @(posedge axis_clk);
            link_rx_valid <= room;
            if (room) begin
                link_rx_beat <= {golden[i].beat, golden[i].sel};
                i++;
            end
        end
        if (i < stop) begin
            note_timeout("link_rx_ready stayed low");
        end
        @(posedge axis_clk);
        link_rx_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge axis_clk);
        for (int n = 0; n < wait_limit && axis_switch_checker_i.pending() != 0; n++) begin
            @(negedge axis_clk);
        end
        if (axis_switch_checker_i.pending() != 0) begin
            note_timeout("destination beats never arrived");
        end
    endtask

    task automatic run_test(input int first, input int stop);
        for (int i = first; i < stop; i++) begin
            axis_switch_checker_i.expect_beat(golden[i].dir, golden[i].dest, golden[i].beat);
        end
        @(posedge axis_clk);
        if (!golden[first].dir) begin
            fork
                begin
                    if (golden[first].mode == 2) begin
                        for (int s = 0; s < num_sources; s++) begin
                            drive_source(s, first, stop);
                        end
                    end else begin
                        fork
                            drive_source(0, first, stop);
                            drive_source(1, first, stop);
                            drive_source(2, first, stop);
                        join
                    end
                end
                pace_tx_ready(golden[first].mode == 1);
            join
        end else begin
            up_rx_ready <= (golden[first].mode != 2);
            aa_rx_ready <= (golden[first].mode != 2);
            send_link_beats(first, stop);
            if (golden[first].mode == 2) begin
                axis_switch_checker_i.check_rx_ready(1'b0);
                @(posedge axis_clk);
                up_rx_ready <= 1'b1;
                aa_rx_ready <= 1'b1;
            end
            wait_drained();
            axis_switch_checker_i.check_rx_ready(1'b1);
        end
        axis_switch_checker_i.end_test(golden[first].test);
    endtask

    initial begin
        int    fd;
        int    first;
        int    stop;
        int    col [9];
        string text;

        axi_reset_n   = 1'b0;
        src_beat      = '{default: '0};
        src_valid     = '0;
        link_tx_ready = 1'b1;
        link_rx_beat  = '0;
        link_rx_valid = 1'b0;
        up_rx_ready   = 1'b1;
        aa_rx_ready   = 1'b1;
        aborted       = 1'b0;
        line_count    = 0;
        void'($urandom(32'hf13605e2));

        fd = $fopen("bench/axis_switch_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/axis_switch_golden.txt");
            aborted = 1'b1;
        end else begin
            while ($fgets(text, fd) != 0 && line_count < max_lines) begin
                if (text.len() > 1 && text[0] != "#" &&
                    $sscanf(text, "%d %d %d %h %h %d %d %d %d", col[0], col[1], col[2],
                            col[3], col[4], col[5], col[6], col[7], col[8]) == 9) begin
                    golden[line_count].test       = 8'(col[0]);
                    golden[line_count].dir        = col[1][0];
                    golden[line_count].sel        = tid_t'(col[2]);
                    golden[line_count].beat.tdata = data_t'(col[3]);
                    golden[line_count].beat.tkeep = keep_t'(col[4]);
                    golden[line_count].beat.tlast = col[5][0];
                    golden[line_count].beat.tuser = user_t'(col[6]);
                    golden[line_count].mode       = 2'(col[7]);
                    golden[line_count].dest       = tid_t'(col[8]);
                    line_count++;
                end
            end
            $fclose(fd);
        end

        repeat (5) @(posedge axis_clk);
        axi_reset_n <= 1'b1;
        axis_switch_checker_i.check_idle();
        axis_switch_checker_i.end_test(1);

        // Lines of one test sit next to each other
        first = 0;
        while (first < line_count && !aborted) begin
            stop = first;
            while (stop < line_count && golden[stop].test == golden[first].test) begin
                stop++;
            end
            run_test(first, stop);
            first = stop;
        end

        axis_switch_checker_i.report();
        if (aborted || line_count == 0 || axis_switch_checker_i.error_count != 0) begin
            $display("Test failed");
        end else begin
            $display("Test passed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
src/axis_sw_pkg.sv
src/frame_arbiter.sv
src/upstream_mux.sv
src/downstream_demux.sv
src/axis_switch.sv
bench/axis_switch_checker.sv
bench/axis_switch_tb.sv

// ==== bench/axis_switch_golden.txt ====
# test dir(0 up, 1 down) sel(source or tid) tdata tkeep tlast tuser mode dest(tid, rx port, 3 none)
# mode: up 0 together, 1 together with tx ready gaps, 2 one source at a time; down 2 holds rx readies
2 0 0 a0000001 f 1 0 2 0
2 0 1 b0000001 f 1 1 2 1
2 0 2 c0000001 3 1 2 2 2
3 0 0 a0000102 f 0 0 0 0
3 0 0 a0000103 f 1 0 0 0
3 0 1 b0000102 f 1 1 0 1
3 0 2 c0000102 1 1 3 0 2
3 0 0 a0000204 f 1 2 0 0
4 0 1 b0000305 f 0 0 1 1
4 0 1 b0000306 f 1 0 1 1
4 0 2 c0000305 7 1 1 1 2
5 1 0 d0000501 f 1 0 0 0
5 1 2 d0000502 f 1 0 0 3
5 1 1 d0000503 3 0 2 0 1
5 1 3 d0000504 f 1 0 0 3
5 1 0 d0000505 f 0 1 0 0
6 1 0 e0000601 f 0 0 2 0
6 1 1 e0000602 f 0 1 2 1
6 1 1 e0000603 f 1 1 2 1
6 1 0 e0000604 3 0 0 2 0
6 1 1 e0000605 f 0 2 2 1
6 1 0 e0000606 f 1 0 2 0
6 1 0 e0000607 1 1 3 2 0
